/* files.f */
+incdir+hw
+incdir+bench
hw/nlc_pkg.sv
hw/nlc_coeff_bank.sv
hw/nlc_mul_pipe.sv
hw/nlc_normalizer.sv
hw/nlc_horner_engine.sv
hw/nlc_controller.sv
bench/nlc_controller_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the corrector testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary -Wno-fatal --top-module nlc_controller_tb -f files.f -o nlc_sim \
	&& ./obj_dir/nlc_sim | tee sim.log \
	|| echo "build or simulation reported an error"
grep -q "all tests passed" sim.log 2>/dev/null \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }

/* bench/nlc_tb_vectors.svh */
`ifndef NLC_TB_VECTORS_SVH
`define NLC_TB_VECTORS_SVH

// How a case loads the coefficient bank
typedef enum logic [1:0] {
	CFG_LINEAR,
	CFG_RANDOM,
	CFG_ONE_CH
} cfg_mode_t;

// Columns: mode, rewritten channel, second srdyi, expected given,
// neg_mean, recip, samples and expected x_lin per channel
typedef struct packed {
	cfg_mode_t                           mode;
	nlc_pkg::ch_idx_t                    target_ch;
	logic                                retrigger;
	logic                                has_expected;
	nlc_pkg::word_t   [0:`NLC_NUM_CH-1]  mean;
	nlc_pkg::word_t   [0:`NLC_NUM_CH-1]  recip;
	nlc_pkg::sample_t [0:`NLC_NUM_CH-1]  samples;
	nlc_pkg::sample_t [0:`NLC_NUM_CH-1]  expected;
} tb_case_t;

localparam int NUM_CASES = 6;

// Case 5 reuses the samples of case 4 with channel 2 rewritten
tb_case_t case_table [NUM_CASES] = '{
	'{mode: CFG_LINEAR, target_ch: 2'd0, retrigger: 1'b0, has_expected: 1'b1,
		mean: '{0, 0, 0, 0}, recip: '{256, 256, 256, 256},
		samples: '{1048575, -1048576, 12345, -7},
		expected: '{1048575, -1048576, 12345, -7}},
	'{mode: CFG_LINEAR, target_ch: 2'd0, retrigger: 1'b0, has_expected: 1'b0,
		mean: '{-2560, 1024, 0, 300}, recip: '{128, 512, 384, 200},
		samples: '{100, -50, 777, -3000}, expected: '{0, 0, 0, 0}},
	'{mode: CFG_RANDOM, target_ch: 2'd0, retrigger: 1'b0, has_expected: 1'b0,
		mean: '{0, 0, 0, 0}, recip: '{0, 0, 0, 0},
		samples: '{3, -5, 7, -2}, expected: '{0, 0, 0, 0}},
	'{mode: CFG_RANDOM, target_ch: 2'd0, retrigger: 1'b1, has_expected: 1'b0,
		mean: '{0, 0, 0, 0}, recip: '{0, 0, 0, 0},
		samples: '{-4, 6, 1, -8}, expected: '{0, 0, 0, 0}},
	'{mode: CFG_RANDOM, target_ch: 2'd0, retrigger: 1'b0, has_expected: 1'b0,
		mean: '{0, 0, 0, 0}, recip: '{0, 0, 0, 0},
		samples: '{5, -1, 2, -6}, expected: '{0, 0, 0, 0}},
	'{mode: CFG_ONE_CH, target_ch: 2'd2, retrigger: 1'b0, has_expected: 1'b0,
		mean: '{0, 0, 0, 0}, recip: '{0, 0, 0, 0},
		samples: '{5, -1, 2, -6}, expected: '{0, 0, 0, 0}}
};

`endif

/* bench/nlc_controller_tb.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_controller_tb;

	localparam int N            = `NLC_NUM_CH;
	localparam int NUM_SEL      = `NLC_ORDER + 3;
	localparam int ONE          = 1 << `NLC_FRAC;
	localparam int PERIOD       = 20;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 20;
	localparam int RETRY_WINDOW = 60;
	localparam int CASE_BOUND   = (`NLC_ORDER + 2) * N * (`NLC_MUL_LAT + 2);

	`include "nlc_tb_vectors.svh"

	localparam int LIMIT_CYCLES = NUM_CASES * CASE_BOUND + RESET_CYCLES + IDLE_CYCLES;

	logic                 clk;
	logic                 rst;
	logic                 srdyi;
	nlc_pkg::sample_vec_t x_adc;
	logic                 cfg_wr;
	nlc_pkg::ch_idx_t     cfg_ch;
	nlc_pkg::coeff_sel_t  cfg_sel;
	nlc_pkg::word_t       cfg_data;
	logic                 srdyo;
	nlc_pkg::sample_vec_t x_lin;

	// Bank contents as written, indexed like the selector enum
	int shadow [N][NUM_SEL];

	nlc_controller nlc_controller_inst (
		.clk     (clk),
		.rst     (rst),
		.srdyi   (srdyi),
		.x_adc   (x_adc),
		.cfg_wr  (cfg_wr),
		.cfg_ch  (cfg_ch),
		.cfg_sel (cfg_sel),
		.cfg_data(cfg_data),
		.srdyo   (srdyo),
		.x_lin   (x_lin)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	function automatic int sext(input nlc_pkg::sample_t s);
		return int'(s);
	endfunction

	function automatic int rand_signed(input int mag);
		return int'($urandom_range(2 * mag)) - mag;
	endfunction

	function automatic int fx_mul(input int a, input int b);
		longint prod;
		prod = longint'(a) * longint'(b);
		return int'(prod >>> `NLC_FRAC);
	endfunction

	// Drop the fraction, then wrap into the 21-bit output range
	function automatic int to_output(input int w);
		int t;
		t = w >>> `NLC_FRAC;
		t = t <<< (32 - `NLC_ADC_W);
		return t >>> (32 - `NLC_ADC_W);
	endfunction

	function automatic int model_channel(input int c, input int s);
		int x;
		int acc;
		x = fx_mul((s <<< `NLC_FRAC) + shadow[c][0], shadow[c][1]);
		acc = shadow[c][2 + `NLC_ORDER];
		for (int k = `NLC_ORDER - 1; k >= 0; k--) begin
			acc = fx_mul(acc, x) + shadow[c][2 + k];
		end
		return to_output(acc);
	endfunction

	task automatic check(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("FAILED at time %0t: %s, got %0d, expected %0d",
				$time, what, actual, expected);
			$display("tests failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic write_coef(input int ch, input int sel, input int data);
		cfg_wr   = 1'b1;
		cfg_ch   = nlc_pkg::ch_idx_t'(ch);
		cfg_sel  = nlc_pkg::coeff_sel_t'(sel);
		cfg_data = data;
		shadow[ch][sel] = data;
		@(negedge clk);
		cfg_wr = 1'b0;
	endtask

	task automatic configure_channel(input int ch, input tb_case_t tc);
		if (tc.mode == CFG_LINEAR) begin
			write_coef(ch, 0, tc.mean[ch]);
			write_coef(ch, 1, tc.recip[ch]);
			for (int k = 0; k <= `NLC_ORDER; k++) begin
				write_coef(ch, 2 + k, (k == 1) ? ONE : 0);
			end
		end else begin
			// Mean within 2.0 and scale between 0.5 and 2.0
			write_coef(ch, 0, rand_signed(512));
			write_coef(ch, 1, 128 + int'($urandom_range(384)));
			for (int k = 0; k <= `NLC_ORDER; k++) begin
				write_coef(ch, 2 + k, rand_signed(256));
			end
		end
	endtask

	task automatic run_case(input int idx);
		tb_case_t tc;
		int       expected [N];
		int       pulses;
		tc = case_table[idx];
		for (int c = 0; c < N; c++) begin
			if (tc.mode != CFG_ONE_CH || c == int'(tc.target_ch)) begin
				configure_channel(c, tc);
			end
		end
		for (int c = 0; c < N; c++) begin
			expected[c] = tc.has_expected ? sext(tc.expected[c])
				: model_channel(c, sext(tc.samples[c]));
			x_adc[c] = tc.samples[c];
		end
		srdyi = 1'b1;
		@(negedge clk);
		srdyi = 1'b0;
		if (tc.retrigger) begin
			// Different samples that must never reach the output
			repeat (3) @(negedge clk);
			for (int c = 0; c < N; c++) begin
				x_adc[c] = nlc_pkg::sample_t'(1 - sext(tc.samples[c]));
			end
			srdyi = 1'b1;
			@(negedge clk);
			srdyi = 1'b0;
		end
		while (!srdyo) @(negedge clk);
		pulses = 1;
		for (int c = 0; c < N; c++) begin
			check(sext(x_lin[c]), expected[c], $sformatf("case %0d x_lin[%0d]", idx, c));
		end
		if (tc.retrigger) begin
			repeat (RETRY_WINDOW) begin
				@(negedge clk);
				if (srdyo) pulses++;
			end
			check(pulses, 1, $sformatf("case %0d srdyo pulse count", idx));
			for (int c = 0; c < N; c++) begin
				check(sext(x_lin[c]), expected[c], $sformatf("case %0d held x_lin[%0d]", idx, c));
			end
		end
		@(negedge clk);
	endtask

	// Watchdog
	initial begin
		#(LIMIT_CYCLES * PERIOD);
		$display("Timeout: srdyo never arrived within %0d clock cycles", LIMIT_CYCLES);
		$display("tests failed");
		$fatal(1, "watchdog expired");
	end

	initial begin
		void'($urandom(94));
		rst      = 1'b1;
		srdyi    = 1'b0;
		cfg_wr   = 1'b0;
		cfg_ch   = '0;
		cfg_sel  = nlc_pkg::SEL_NEG_MEAN;
		cfg_data = '0;
		for (int c = 0; c < N; c++) begin
			x_adc[c] = '0;
			for (int s = 0; s < NUM_SEL; s++) begin
				shadow[c][s] = 0;
			end
		end
		repeat (RESET_CYCLES) @(negedge clk);
		rst = 1'b0;

		// Quiet outputs before the first strobe
		repeat (IDLE_CYCLES) begin
			@(negedge clk);
			check(int'(srdyo), 0, "srdyo after reset");
			for (int c = 0; c < N; c++) begin
				check(sext(x_lin[c]), 0, $sformatf("x_lin[%0d] after reset", c));
			end
		end

		for (int i = 0; i < NUM_CASES; i++) begin
			run_case(i);
		end

		$display("all tests passed");
		$finish;
	end

endmodule

/* hw/nlc_controller.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_controller (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 srdyi,
	input  nlc_pkg::sample_vec_t x_adc,
	input  logic                 cfg_wr,
	input  nlc_pkg::ch_idx_t     cfg_ch,
	input  nlc_pkg::coeff_sel_t  cfg_sel,
	input  nlc_pkg::word_t       cfg_data,
	output logic                 srdyo,
	output nlc_pkg::sample_vec_t x_lin
);

	nlc_pkg::ch_idx_t    norm_rd_ch;
	nlc_pkg::word_t      neg_mean;
	nlc_pkg::word_t      recip;
	nlc_pkg::word_t      norm_vec [`NLC_NUM_CH];
	logic                norm_done;
	nlc_pkg::ch_idx_t    coef_rd_ch;
	nlc_pkg::coeff_sel_t coef_rd_sel;
	nlc_pkg::word_t      coef_data;
	logic                engine_busy;

	nlc_coeff_bank coeff_bank_inst (
		.clk        (clk),
		.rst        (rst),
		.cfg_wr     (cfg_wr),
		.cfg_ch     (cfg_ch),
		.cfg_sel    (cfg_sel),
		.cfg_data   (cfg_data),
		.norm_rd_ch (norm_rd_ch),
		.coef_rd_ch (coef_rd_ch),
		.coef_rd_sel(coef_rd_sel),
		.neg_mean   (neg_mean),
		.recip      (recip),
		.coef_data  (coef_data)
	);

	// Capture and normalize
	nlc_normalizer normalizer_inst (
		.clk        (clk),
		.rst        (rst),
		.srdyi      (srdyi),
		.x_adc      (x_adc),
		.engine_busy(engine_busy),
		.neg_mean   (neg_mean),
		.recip      (recip),
		.norm_rd_ch (norm_rd_ch),
		.norm_vec   (norm_vec),
		.norm_done  (norm_done)
	);

	// Main loop and output conversion
	nlc_horner_engine horner_engine_inst (
		.clk        (clk),
		.rst        (rst),
		.norm_done  (norm_done),
		.norm_vec   (norm_vec),
		.coef_data  (coef_data),
		.coef_rd_ch (coef_rd_ch),
		.coef_rd_sel(coef_rd_sel),
		.engine_busy(engine_busy),
		.x_lin      (x_lin),
		.srdyo      (srdyo)
	);

endmodule

/* hw/nlc_horner_engine.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_horner_engine (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 norm_done,
	input  nlc_pkg::word_t       norm_vec [`NLC_NUM_CH],
	input  nlc_pkg::word_t       coef_data,
	output nlc_pkg::ch_idx_t     coef_rd_ch,
	output nlc_pkg::coeff_sel_t  coef_rd_sel,
	output logic                 engine_busy,
	output nlc_pkg::sample_vec_t x_lin,
	output logic                 srdyo
);

	localparam int N = `NLC_NUM_CH;
	localparam nlc_pkg::ch_idx_t LAST_CH = nlc_pkg::ch_idx_t'(N - 1);
	localparam nlc_pkg::order_t FIRST_STEP = nlc_pkg::order_t'(`NLC_ORDER - 1);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_RUN,
		ST_CONV
	} state_t;

	state_t                state;
	nlc_pkg::ch_idx_t      ld_ch;
	nlc_pkg::ch_idx_t      rr_ch;
	nlc_pkg::order_t       step [N];
	logic [N-1:0]          pending;
	logic [N-1:0]          done;
	nlc_pkg::word_t        acc [N];

	logic                  issue;
	nlc_pkg::horner_tag_t  issue_tag;
	logic                  ret_valid;
	nlc_pkg::word_t        ret_p;
	nlc_pkg::horner_tag_t  ret_tag;

	function automatic nlc_pkg::sample_t to_sample(input nlc_pkg::word_t w);
		nlc_pkg::word_t shifted;
		shifted = w >>> `NLC_FRAC;
		return shifted[`NLC_ADC_W-1:0];
	endfunction

	// A channel with a product in flight has to wait its turn
	assign issue = (state == ST_RUN) && !pending[rr_ch] && !done[rr_ch];

	always_comb begin
		issue_tag.ch   = rr_ch;
		issue_tag.step = step[rr_ch];
	end

	assign engine_busy = (state != ST_IDLE);

	// c5 during load, otherwise the coefficient of the returning product
	always_comb begin
		if (state == ST_LOAD) begin
			coef_rd_ch  = ld_ch;
			coef_rd_sel = nlc_pkg::SEL_C5;
		end else begin
			coef_rd_ch  = ret_tag.ch;
			coef_rd_sel = nlc_pkg::coeff_sel_t'(nlc_pkg::SEL_C0 + ret_tag.step);
		end
	end

	nlc_mul_pipe #(
		.tag_t(nlc_pkg::horner_tag_t)
	) mul_pipe_inst (
		.clk      (clk),
		.rst      (rst),
		.in_valid (issue),
		.a        (acc[rr_ch]),
		.b        (norm_vec[rr_ch]),
		.in_tag   (issue_tag),
		.out_valid(ret_valid),
		.p        (ret_p),
		.out_tag  (ret_tag)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= ST_IDLE;
			ld_ch   <= '0;
			rr_ch   <= '0;
			pending <= '0;
			done    <= '0;
			srdyo   <= 1'b0;
			for (int c = 0; c < N; c++) begin
				step[c]  <= '0;
				x_lin[c] <= '0;
			end
		end else begin
			srdyo <= 1'b0;
			case (state)
				ST_IDLE: begin
					if (norm_done) begin
						state   <= ST_LOAD;
						ld_ch   <= '0;
						pending <= '0;
						done    <= '0;
						for (int c = 0; c < N; c++) begin
							step[c] <= FIRST_STEP;
						end
					end
				end
				ST_LOAD: begin
					ld_ch <= ld_ch + 1'b1;
					if (ld_ch == LAST_CH) begin
						state <= ST_RUN;
						rr_ch <= '0;
					end
				end
				ST_RUN: begin
					rr_ch <= (rr_ch == LAST_CH) ? '0 : rr_ch + 1'b1;
					if (issue) begin
						pending[rr_ch] <= 1'b1;
					end
					if (ret_valid) begin
						pending[ret_tag.ch] <= 1'b0;
						if (ret_tag.step == '0) begin
							done[ret_tag.ch] <= 1'b1;
						end else begin
							step[ret_tag.ch] <= ret_tag.step - 1'b1;
						end
					end
					if (&done) begin
						state <= ST_CONV;
					end
				end
				ST_CONV: begin
					for (int c = 0; c < N; c++) begin
						x_lin[c] <= to_sample(acc[c]);
					end
					srdyo <= 1'b1;
					state <= ST_IDLE;
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// acc = acc * x + ck, the add sits on the multiplier output
	always_ff @(posedge clk) begin
		if (state == ST_LOAD) begin
			acc[ld_ch] <= coef_data;
		end else if (ret_valid) begin
			acc[ret_tag.ch] <= ret_p + coef_data;
		end
	end

endmodule

/* hw/nlc_normalizer.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_normalizer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 srdyi,
	input  nlc_pkg::sample_vec_t x_adc,
	input  logic                 engine_busy,
	input  nlc_pkg::word_t       neg_mean,
	input  nlc_pkg::word_t       recip,
	output nlc_pkg::ch_idx_t     norm_rd_ch,
	output nlc_pkg::word_t       norm_vec [`NLC_NUM_CH],
	output logic                 norm_done
);

	localparam nlc_pkg::ch_idx_t LAST_CH = nlc_pkg::ch_idx_t'(`NLC_NUM_CH - 1);

	logic                 busy;
	logic                 issuing;
	logic                 accept;
	nlc_pkg::ch_idx_t     issue_ch;
	nlc_pkg::sample_vec_t x_q;
	nlc_pkg::word_t       conv_word;
	nlc_pkg::word_t       sum_word;

	logic                 mul_valid;
	nlc_pkg::word_t       mul_p;
	nlc_pkg::ch_idx_t     mul_tag;

	// New samples only when the whole datapath is free
	assign accept = srdyi && !busy && !engine_busy;

	always_ff @(posedge clk) begin
		if (accept) begin
			x_q <= x_adc;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			busy      <= 1'b0;
			issuing   <= 1'b0;
			issue_ch  <= '0;
			norm_done <= 1'b0;
		end else begin
			norm_done <= mul_valid && (mul_tag == LAST_CH);
			if (accept) begin
				busy     <= 1'b1;
				issuing  <= 1'b1;
				issue_ch <= '0;
			end else if (issuing) begin
				if (issue_ch == LAST_CH) begin
					issuing  <= 1'b0;
					issue_ch <= '0;
				end else begin
					issue_ch <= issue_ch + 1'b1;
				end
			end
			if (norm_done) begin
				busy <= 1'b0;
			end
		end
	end

	// Sample to fixed point, plus the channel's negative mean
	assign conv_word  = nlc_pkg::word_t'(x_q[issue_ch]) <<< `NLC_FRAC;
	assign sum_word   = conv_word + neg_mean;
	assign norm_rd_ch = issue_ch;

	nlc_mul_pipe #(
		.tag_t(nlc_pkg::ch_idx_t)
	) mul_pipe_inst (
		.clk      (clk),
		.rst      (rst),
		.in_valid (issuing),
		.a        (sum_word),
		.b        (recip),
		.in_tag   (issue_ch),
		.out_valid(mul_valid),
		.p        (mul_p),
		.out_tag  (mul_tag)
	);

	// Tag says where the product belongs
	always_ff @(posedge clk) begin
		if (mul_valid) begin
			norm_vec[mul_tag] <= mul_p;
		end
	end

endmodule

/* hw/nlc_mul_pipe.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_mul_pipe #(
	parameter type tag_t = nlc_pkg::ch_idx_t
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           in_valid,
	input  nlc_pkg::word_t a,
	input  nlc_pkg::word_t b,
	input  tag_t           in_tag,
	output logic           out_valid,
	output nlc_pkg::word_t p,
	output tag_t           out_tag
);

	localparam int LAT = `NLC_MUL_LAT;
	localparam int W   = `NLC_WORD_W;

	logic signed [2*W-1:0] full_prod;
	logic signed [2*W-1:0] scaled_prod;

	logic [LAT-1:0] valid_q;
	nlc_pkg::word_t prod_q [LAT];
	tag_t           tag_q  [LAT];

	// Full product, then drop the extra fraction bits
	assign full_prod   = a * b;
	assign scaled_prod = full_prod >>> `NLC_FRAC;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q[0] <= in_valid;
			for (int i = 1; i < LAT; i++) begin
				valid_q[i] <= valid_q[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		prod_q[0] <= scaled_prod[W-1:0];
		tag_q[0]  <= in_tag;
		for (int i = 1; i < LAT; i++) begin
			prod_q[i] <= prod_q[i-1];
			tag_q[i]  <= tag_q[i-1];
		end
	end

	assign out_valid = valid_q[LAT-1];
	assign p         = prod_q[LAT-1];
	assign out_tag   = tag_q[LAT-1];

endmodule

/* hw/nlc_coeff_bank.sv */
`timescale 1ns/1ps
`include "nlc_macros.svh"

module nlc_coeff_bank (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cfg_wr,
	input  nlc_pkg::ch_idx_t     cfg_ch,
	input  nlc_pkg::coeff_sel_t  cfg_sel,
	input  nlc_pkg::word_t       cfg_data,
	input  nlc_pkg::ch_idx_t     norm_rd_ch,
	input  nlc_pkg::ch_idx_t     coef_rd_ch,
	input  nlc_pkg::coeff_sel_t  coef_rd_sel,
	output nlc_pkg::word_t       neg_mean,
	output nlc_pkg::word_t       recip,
	output nlc_pkg::word_t       coef_data
);

	// Mean, reciprocal deviation and c0..c5 per channel
	localparam int NUM_SEL = `NLC_ORDER + 3;

	nlc_pkg::word_t regs [`NLC_NUM_CH][NUM_SEL];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int c = 0; c < `NLC_NUM_CH; c++) begin
				for (int s = 0; s < NUM_SEL; s++) begin
					regs[c][s] <= '0;
				end
			end
		end else if (cfg_wr) begin
			regs[cfg_ch][cfg_sel] <= cfg_data;
		end
	end

	// Normalizer port
	assign neg_mean = regs[norm_rd_ch][nlc_pkg::SEL_NEG_MEAN];
	assign recip    = regs[norm_rd_ch][nlc_pkg::SEL_RECIP];

	// Horner port, any selector
	assign coef_data = regs[coef_rd_ch][coef_rd_sel];

endmodule

/* hw/nlc_pkg.sv */
`include "nlc_macros.svh"

package nlc_pkg;

	typedef logic signed [`NLC_ADC_W-1:0] sample_t;
	typedef logic signed [`NLC_WORD_W-1:0] word_t;
	typedef logic [$clog2(`NLC_NUM_CH)-1:0] ch_idx_t;
	typedef logic [2:0] order_t;

	// Coefficient bank selector, c0 to c5 are contiguous
	typedef enum logic [2:0] {
		SEL_NEG_MEAN = 3'd0,
		SEL_RECIP    = 3'd1,
		SEL_C0       = 3'd2,
		SEL_C1       = 3'd3,
		SEL_C2       = 3'd4,
		SEL_C3       = 3'd5,
		SEL_C4       = 3'd6,
		SEL_C5       = 3'd7
	} coeff_sel_t;

	// Travels with each Horner product
	typedef struct packed {
		ch_idx_t ch;
		order_t  step;
	} horner_tag_t;

	typedef sample_t sample_vec_t [`NLC_NUM_CH];

endpackage

/* hw/nlc_macros.svh */
`ifndef NLC_MACROS_SVH
`define NLC_MACROS_SVH

// Channel count of the ADC bank
`define NLC_NUM_CH 4

// Raw sample and corrected output width
`define NLC_ADC_W 21

// Fixed-point word width and its fraction bits
`define NLC_WORD_W 32
`define NLC_FRAC 8

// Polynomial order, coefficients c0 to c5
`define NLC_ORDER 5

// Registered stages in each multiplier
`define NLC_MUL_LAT 3

`endif
